/* ray_geom_pkg.sv */
`default_nettype none

package ray_geom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// coordinate and distance widths
	////////////////////////////////////////////////////////////////////////////

	localparam int COORD_W = 16;
	localparam int DIST_W  = COORD_W * 2 + 1; // 17-bit diff times 16-bit inv_dir

	typedef logic signed [COORD_W-1:0] coord_t; // position or inverse direction
	typedef logic signed [DIST_W-1:0]  dist_t;  // parametric distance along the ray

	// open span used on an axis the ray runs parallel to
	localparam dist_t DIST_MAX = {1'b0, {(DIST_W-1){1'b1}}};
	localparam dist_t DIST_MIN = {1'b1, {(DIST_W-1){1'b0}}};

	////////////////////////////////////////////////////////////////////////////
	// query, span and result types
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		coord_t origin_x;
		coord_t origin_y;
		coord_t origin_z;
		coord_t inv_dir_x; // 1/dir, meaningless when the axis is parallel
		coord_t inv_dir_y;
		coord_t inv_dir_z;
		coord_t box_min_x;
		coord_t box_min_y;
		coord_t box_min_z;
		coord_t box_max_x;
		coord_t box_max_y;
		coord_t box_max_z;
		logic   parallel_x; // ray has no x component
		logic   parallel_y;
		logic   parallel_z;
	} ray_query_t;

	typedef struct packed {
		dist_t t_enter;
		dist_t t_exit;
		logic  outside; // parallel axis with origin beyond a plane
	} axis_span_t;

	typedef struct packed {
		axis_span_t x;
		axis_span_t y;
		axis_span_t z;
	} span_bundle_t;

	typedef enum logic [1:0] {
		verdict_hit,
		verdict_outside_slab,
		verdict_disjoint,
		verdict_behind
	} verdict_e;

	typedef struct packed {
		verdict_e verdict;
		logic     hit;
		dist_t    tnear;
		dist_t    tfar;
	} hit_result_t;

endpackage

`default_nettype wire

/* ray_flow_pkg.sv */
`default_nettype none

package ray_flow_pkg;

	////////////////////////////////////////////////////////////////////////////
	// credit flow between producer and span buffer
	////////////////////////////////////////////////////////////////////////////

	localparam int CREDIT_W = 4;

	// default depth of the span buffer, also the initial credit count
	localparam int FIFO_DEPTH_DEFAULT = 4;

	// holds 0..15, so any buffer depth up to 15 fits
	typedef logic [CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

/* slab_interval_gen.sv */
`default_nettype none

module slab_interval_gen import ray_geom_pkg::*, ray_flow_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ray_valid,
	input  ray_query_t  ray,
	output logic        ray_ready,
	input  wire logic   credit_return,
	output logic        span_push,
	output span_bundle_t span_data
);

	typedef logic signed [COORD_W:0] diff_t; // bound minus origin, one bit wider

	// products are exact, then ordered so that t_enter <= t_exit
	function automatic axis_span_t order_span(input diff_t lo, input diff_t hi,
			input coord_t inv, input logic par, input logic out);
		dist_t      p_lo;
		dist_t      p_hi;
		axis_span_t s;
		p_lo = lo * inv;
		p_hi = hi * inv;
		s.outside = out;
		if (par) begin
			s.t_enter = DIST_MIN; // slab never limits a parallel axis
			s.t_exit  = DIST_MAX;
		end else if (inv < 0) begin
			s.t_enter = p_hi; // negative direction enters at the max plane
			s.t_exit  = p_lo;
		end else begin
			s.t_enter = p_lo;
			s.t_exit  = p_hi;
		end
		return s;
	endfunction

	coord_t org  [0:2];
	coord_t inv  [0:2];
	coord_t bmin [0:2];
	coord_t bmax [0:2];
	logic   par  [0:2];

	credit_t credits;
	logic    ray_accept;

	logic   s1_valid;
	diff_t  s1_lo  [0:2];
	diff_t  s1_hi  [0:2];
	coord_t s1_inv [0:2];
	logic   s1_par [0:2];
	logic   s1_out [0:2];

	logic         s2_valid;
	span_bundle_t s2_data;

	always_comb begin
		org  = '{ray.origin_x, ray.origin_y, ray.origin_z};
		inv  = '{ray.inv_dir_x, ray.inv_dir_y, ray.inv_dir_z};
		bmin = '{ray.box_min_x, ray.box_min_y, ray.box_min_z};
		bmax = '{ray.box_max_x, ray.box_max_y, ray.box_max_z};
		par  = '{ray.parallel_x, ray.parallel_y, ray.parallel_z};
	end

	assign ray_ready  = (credits != '0);
	assign ray_accept = ray_valid && ray_ready;

	////////////////////////////////////////////////////////////////////////////
	// credits, one per free buffer slot
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits  <= credit_t'(FIFO_DEPTH);
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			credits  <= credits - credit_t'(ray_accept) + credit_t'(credit_return);
			s1_valid <= ray_accept;
			s2_valid <= s1_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// datapath, stage one differences, stage two products
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			s1_lo[i]  <= bmin[i] - org[i];
			s1_hi[i]  <= bmax[i] - org[i];
			s1_inv[i] <= inv[i];
			s1_par[i] <= par[i];
			s1_out[i] <= par[i] && (org[i] < bmin[i] || org[i] > bmax[i]);
		end
		s2_data.x <= order_span(s1_lo[0], s1_hi[0], s1_inv[0], s1_par[0], s1_out[0]);
		s2_data.y <= order_span(s1_lo[1], s1_hi[1], s1_inv[1], s1_par[1], s1_out[1]);
		s2_data.z <= order_span(s1_lo[2], s1_hi[2], s1_inv[2], s1_par[2], s1_out[2]);
	end

	assign span_push = s2_valid; // always backed by a credit
	assign span_data = s2_data;

endmodule

`default_nettype wire

/* span_fifo.sv */
`default_nettype none

module span_fifo import ray_geom_pkg::*, ray_flow_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    span_push,
	input  span_bundle_t span_data,
	input  wire logic    span_pop,
	output logic         span_avail,
	output span_bundle_t span_head,
	output logic         credit_return
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;

	// wrap at FIFO_DEPTH, which need not be a power of two
	function automatic ptr_t next_ptr(input ptr_t p);
		ptr_t n;
		if (p == ptr_t'(FIFO_DEPTH - 1))
			n = '0;
		else
			n = p + 1'b1;
		return n;
	endfunction

	span_bundle_t mem [0:FIFO_DEPTH-1];

	ptr_t    wr_ptr;
	ptr_t    rd_ptr;
	credit_t count;

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (span_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (span_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({span_push, span_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
			credit_return <= span_pop; // slot freed, hand credit back
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (span_push)
			mem[wr_ptr] <= span_data;
	end

	assign span_avail = (count != '0);
	assign span_head  = mem[rd_ptr]; // head valid only with span_avail

endmodule

`default_nettype wire

/* slab_hit_resolver.sv */
`default_nettype none

module slab_hit_resolver import ray_geom_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    span_avail,
	input  span_bundle_t span_head,
	output logic         span_pop,
	input  wire logic    result_ready,
	output logic         result_valid,
	output hit_result_t  result
);

	function automatic dist_t dist_max2(input dist_t a, input dist_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic dist_t dist_min2(input dist_t a, input dist_t b);
		return (a < b) ? a : b;
	endfunction

	dist_t       tnear;
	dist_t       tfar;
	logic        any_outside;
	verdict_e    verdict;
	hit_result_t next_result;

	////////////////////////////////////////////////////////////////////////////
	// reduce three spans to one interval
	////////////////////////////////////////////////////////////////////////////

	assign tnear = dist_max2(dist_max2(span_head.x.t_enter, span_head.y.t_enter),
		span_head.z.t_enter); // last entry into a slab
	assign tfar  = dist_min2(dist_min2(span_head.x.t_exit, span_head.y.t_exit),
		span_head.z.t_exit); // first exit from a slab

	assign any_outside = span_head.x.outside || span_head.y.outside ||
		span_head.z.outside;

	always_comb begin
		if (any_outside)
			verdict = verdict_outside_slab;
		else if (tfar < tnear)
			verdict = verdict_disjoint;
		else if (tfar <= dist_t'(0))
			verdict = verdict_behind; // box lies behind the origin
		else
			verdict = verdict_hit;
	end

	always_comb begin
		next_result.verdict = verdict;
		next_result.hit     = (verdict == verdict_hit);
		next_result.tnear   = tnear;
		next_result.tfar    = tfar;
	end

	////////////////////////////////////////////////////////////////////////////
	// output register with back-pressure
	////////////////////////////////////////////////////////////////////////////

	// take a new span when the register is empty or draining this cycle
	assign span_pop = span_avail && (!result_valid || result_ready);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else begin
			if (span_pop)
				result_valid <= 1'b1;
			else if (result_ready)
				result_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (span_pop)
			result <= next_result; // held until the consumer reads it
	end

endmodule

`default_nettype wire

/* ray_box_top.sv */
`default_nettype none

module ray_box_top import ray_geom_pkg::*, ray_flow_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT // any depth from 2 to 15
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ray_valid,
	input  ray_query_t  ray,
	output logic        ray_ready,
	output logic        result_valid,
	output hit_result_t result,
	input  wire logic   result_ready
);

	logic         span_push;
	span_bundle_t span_data;
	logic         credit_return;
	logic         span_avail;
	span_bundle_t span_head;
	logic         span_pop;

	slab_interval_gen #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_interval_gen (
		.clk           (clk),
		.rst           (rst),
		.ray_valid     (ray_valid),
		.ray           (ray),
		.ray_ready     (ray_ready),
		.credit_return (credit_return),
		.span_push     (span_push),
		.span_data     (span_data)
	);

	span_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_span_fifo (
		.clk           (clk),
		.rst           (rst),
		.span_push     (span_push),
		.span_data     (span_data),
		.span_pop      (span_pop),
		.span_avail    (span_avail),
		.span_head     (span_head),
		.credit_return (credit_return)
	);

	slab_hit_resolver u_hit_resolver (
		.clk          (clk),
		.rst          (rst),
		.span_avail   (span_avail),
		.span_head    (span_head),
		.span_pop     (span_pop),
		.result_ready (result_ready),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

/* tb_ray_box_checks.svh */
////////////////////////////////////////////////////////////////////////////
// compare tasks, typed to the result and verdict types
////////////////////////////////////////////////////////////////////////////

task automatic check_verdict(input string test, input verdict_e exp, input verdict_e act);
	if (act !== exp) begin
		$display("ERROR %s verdict: expected %s, actual %s", test, exp.name(), act.name());
		abort_sim();
	end
endtask

task automatic check_dist(input string test, input string field, input dist_t exp,
		input dist_t act);
	if (act !== exp) begin
		$display("ERROR %s %s: expected %0d, actual %0d", test, field, exp, act);
		abort_sim();
	end
endtask

// whole result, verdict first since it explains the rest
task automatic check_result(input string test, input hit_result_t exp,
		input hit_result_t act);
	check_verdict(test, exp.verdict, act.verdict);
	if (act.hit !== exp.hit) begin
		$display("ERROR %s hit: expected %0b, actual %0b", test, exp.hit, act.hit);
		abort_sim();
	end
	check_dist(test, "tnear", exp.tnear, act.tnear);
	check_dist(test, "tfar", exp.tfar, act.tfar);
endtask

/* tb_ray_box.sv */
`default_nettype none

module tb_ray_box import ray_geom_pkg::*, ray_flow_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FIFO_DEPTH      = FIFO_DEPTH_DEFAULT;
	localparam int N_DIRECTED      = 24;
	localparam int N_RANDOM        = 200;
	localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;

	logic        clk;
	logic        rst;
	logic        ray_valid;
	ray_query_t  ray;
	logic        ray_ready;
	logic        result_valid;
	hit_result_t result;
	logic        result_ready;

	int          seed = 32'ha02;
	int          ready_mode = 0; // 0 ready, 1 stalled, 2 random
	string       test_name;
	hit_result_t expected_q [$]; // one entry per accepted ray in arrival order

	ray_box_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) DUT (
		.clk          (clk),
		.rst          (rst),
		.ray_valid    (ray_valid),
		.ray          (ray),
		.ray_ready    (ray_ready),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready)
	);

	task abort_sim();
		$display("Simulation FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	`include "tb_ray_box_checks.svh"

	////////////////////////////////////////////////////////////////////////////
	// reference model of the slab rule
	////////////////////////////////////////////////////////////////////////////

	function automatic void axis_model(input coord_t o, input coord_t inv, input coord_t lo,
			input coord_t hi, input logic par, output dist_t t_in, output dist_t t_out,
			output logic out);
		dist_t a;
		dist_t b;
		a   = (dist_t'(lo) - dist_t'(o)) * dist_t'(inv); // exact at full width
		b   = (dist_t'(hi) - dist_t'(o)) * dist_t'(inv);
		out = 1'b0;
		if (par) begin
			t_in  = DIST_MIN;
			t_out = DIST_MAX;
			out   = (o < lo) || (o > hi);
		end else if (inv < 0) begin
			t_in  = b;
			t_out = a;
		end else begin
			t_in  = a;
			t_out = b;
		end
	endfunction

	function automatic hit_result_t model_result(input ray_query_t q);
		dist_t       t_in  [3];
		dist_t       t_out [3];
		logic        out   [3];
		dist_t       tn;
		dist_t       tf;
		hit_result_t r;
		axis_model(q.origin_x, q.inv_dir_x, q.box_min_x, q.box_max_x, q.parallel_x,
			t_in[0], t_out[0], out[0]);
		axis_model(q.origin_y, q.inv_dir_y, q.box_min_y, q.box_max_y, q.parallel_y,
			t_in[1], t_out[1], out[1]);
		axis_model(q.origin_z, q.inv_dir_z, q.box_min_z, q.box_max_z, q.parallel_z,
			t_in[2], t_out[2], out[2]);
		tn = t_in[0];
		tf = t_out[0];
		for (int i = 1; i < 3; i++) begin
			if (t_in[i] > tn)
				tn = t_in[i];
			if (t_out[i] < tf)
				tf = t_out[i];
		end
		if (out[0] || out[1] || out[2])
			r.verdict = verdict_outside_slab;
		else if (tf < tn)
			r.verdict = verdict_disjoint;
		else if (tf <= 0)
			r.verdict = verdict_behind;
		else
			r.verdict = verdict_hit;
		r.hit   = (r.verdict == verdict_hit);
		r.tnear = tn;
		r.tfar  = tf;
		return r;
	endfunction

	// same lo to hi bounds on all three axes with par bits ordered x y z
	function automatic ray_query_t make_ray(input coord_t ox, oy, oz, input coord_t ix, iy, iz,
			input coord_t lo, hi, input logic [2:0] par);
		ray_query_t q;
		q = '{ox, oy, oz, ix, iy, iz, lo, lo, lo, hi, hi, hi, par[2], par[1], par[0]};
		return q;
	endfunction

	function automatic coord_t rand_coord(input int span);
		int v;
		v = $random(seed);
		if (span == 0)
			return coord_t'(v); // full 16-bit range
		return coord_t'(v % span);
	endfunction

	function automatic ray_query_t random_ray();
		coord_t     o   [3];
		coord_t     inv [3];
		coord_t     lo  [3];
		coord_t     hi  [3];
		logic       par [3];
		int         span;
		ray_query_t q;
		span = ($random(seed) % 8 == 0) ? 0 : 64;
		for (int i = 0; i < 3; i++) begin
			o[i]   = rand_coord(span);
			inv[i] = rand_coord(span == 0 ? 0 : 9);
			lo[i]  = rand_coord(span);
			hi[i]  = lo[i] + coord_t'($random(seed) & 63);
			par[i] = ($random(seed) & 7) == 0;
		end
		q = '{o[0], o[1], o[2], inv[0], inv[1], inv[2], lo[0], lo[1], lo[2],
			hi[0], hi[1], hi[2], par[0], par[1], par[2]};
		return q;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// clock, watchdog, result_ready and the result monitor
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		abort_sim();
	end

	initial begin
		logic coin;
		forever begin
			@(posedge clk);
			coin = ($random(seed) % 2) != 0; // random ready for the next cycle
			@(negedge clk);
			case (ready_mode)
				0:       result_ready = 1'b1;
				1:       result_ready = 1'b0;
				default: result_ready = coin;
			endcase
		end
	end

	always @(posedge clk) begin
		if (!rst && result_valid && result_ready) begin
			if (expected_q.size() == 0) begin
				$display("a result came out with no ray outstanding in %s", test_name);
				abort_sim();
			end else begin
				check_result(test_name, expected_q.pop_front(), result);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks that start on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic send_ray(input ray_query_t q);
		ray_valid = 1'b1;
		ray       = q;
		while (!ray_ready)
			@(negedge clk); // credits ran out
		expected_q.push_back(model_result(q));
		@(negedge clk);
		ray_valid = 1'b0;
	endtask

	task automatic send_expect(input ray_query_t q, input verdict_e want);
		hit_result_t exp;
		exp = model_result(q);
		check_verdict({test_name, " (model)"}, want, exp.verdict);
		send_ray(q);
	endtask

	task automatic drain();
		while (expected_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic test_hit_axes();
		test_name = "test_hit_axes";
		send_expect(make_ray(0, 0, 0, 1, 1, 1, 10, 30, 3'b000), verdict_hit);
		send_expect(make_ray(40, 40, 40, -1, -1, -1, 10, 30, 3'b000), verdict_hit);
		send_expect(make_ray(0, 40, 0, 2, -2, 3, 10, 30, 3'b000), verdict_hit);
		send_expect(make_ray(20, 20, 20, 5, -7, 3, 10, 30, 3'b000), verdict_hit);
		send_expect(make_ray(40, 0, 40, -3, 5, -4, 10, 30, 3'b000), verdict_hit);
		send_expect(make_ray(-30000, -30000, -30000, 32767, 32767, 32767, 10, 30, 3'b000),
			verdict_hit); // wide products
		drain();
	endtask

	task automatic test_misses();
		test_name = "test_misses";
		send_expect(make_ray(0, 0, 0, 1, 4, 1, 10, 30, 3'b000), verdict_disjoint);
		send_expect(make_ray(0, 0, 0, -1, 1, 1, 10, 30, 3'b000), verdict_disjoint);
		send_expect(make_ray(40, 40, 40, 1, 1, 1, 10, 30, 3'b000), verdict_behind);
		send_expect(make_ray(50, 40, 45, 1, 1, 1, 10, 30, 3'b000), verdict_behind);
		drain();
	endtask

	task automatic test_parallel();
		test_name = "test_parallel";
		send_expect(make_ray(0, 20, 20, 0, 1, 1, 10, 30, 3'b100), verdict_outside_slab);
		send_expect(make_ray(20, 0, 0, 0, 1, 1, 10, 30, 3'b100), verdict_hit);
		send_expect(make_ray(20, 0, 0, 0, 1, 4, 10, 30, 3'b100), verdict_disjoint);
		send_expect(make_ray(0, 20, 35, 1, 0, 0, 10, 30, 3'b011), verdict_outside_slab);
		send_expect(make_ray(0, 20, 20, 1, 0, 0, 10, 30, 3'b011), verdict_hit);
		send_expect(make_ray(40, 20, 20, 1, 0, 0, 10, 30, 3'b011), verdict_behind);
		send_expect(make_ray(20, 20, 20, 0, 0, 0, 10, 30, 3'b111), verdict_hit);
		drain();
	endtask

	task automatic test_backpressure();
		int accepted;
		test_name  = "test_backpressure";
		accepted   = 0;
		ready_mode = 1;
		@(negedge clk);
		ray_valid = 1'b1;
		repeat (4 * FIFO_DEPTH + 8) begin
			ray = make_ray(coord_t'(accepted), 0, 0, 1, 1, 1, 10, 30, 3'b000);
			if (ray_ready) begin // taken on the coming rising edge
				expected_q.push_back(model_result(ray));
				accepted++;
			end
			@(negedge clk);
		end
		ray_valid = 1'b0;
		if (ray_ready || accepted > FIFO_DEPTH + 1) begin
			$display("back-pressure did not stop the input: %0d rays taken", accepted);
			abort_sim();
		end
		ready_mode = 0;
		drain();
	endtask

	task automatic test_random_stream();
		test_name  = "test_random_stream";
		ready_mode = 2;
		for (int n = 0; n < N_RANDOM; n++) begin
			send_ray(random_ray());
			if (($random(seed) & 3) == 0)
				@(negedge clk); // idle gap
		end
		ready_mode = 0;
		drain();
	endtask

	initial begin
		rst       = 1'b1;
		ray_valid = 1'b0;
		ray       = '0;
		result_ready = 1'b0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		if (!ray_ready || result_valid) begin
			$display("after reset ray_ready should be high and result_valid low");
			abort_sim();
		end
		test_hit_axes();
		test_misses();
		test_parallel();
		test_backpressure();
		test_random_stream();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
ray_geom_pkg.sv
ray_flow_pkg.sv
slab_interval_gen.sv
span_fifo.sv
slab_hit_resolver.sv
ray_box_top.sv
tb_ray_box.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ray_box -f tb.f -o sim_ray_box
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/sim_ray_box 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
